/* compile.f */
logic/fp16_pkg.sv
logic/apb_pkg.sv
logic/lzc.sv
logic/fp16_align.sv
logic/fp16_normalize.sv
logic/fp16_apb_regs.sv
logic/fp16_add_apb_top.sv
tb/tb_clock_gen.sv
tb/fp16_add_checker.sv
tb/tb_fp16_add.sv

/* tb/tb_fp16_add.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fp16_add;
  import apb_pkg::*;

  localparam int N_DIRECTED = 31;
  localparam int N_RANDOM   = 300;
  localparam int NUM_OPS    = N_DIRECTED + N_RANDOM;
  localparam int LIMIT      = NUM_OPS * 20 + 200;

  logic           clk;
  logic           reset;
  apb_req_t       apb_req;
  apb_rsp_t       apb_rsp;
  logic [8*16-1:0] test_name;
  int             errors;
  int             checks;
  int             poll_errors;
  int             cycles;

  tb_clock_gen u_clock_gen (
    .clk_o   (clk),
    .reset_o (reset)
  );

  fp16_add_apb_top #(
    .ADDR_WIDTH (12)
  ) u_fp16_add_apb_top (
    .clk_i     (clk),
    .reset_i   (reset),
    .apb_req_i (apb_req),
    .apb_rsp_o (apb_rsp)
  );

  fp16_add_checker u_checker (
    .clk_i       (clk),
    .reset_i     (reset),
    .apb_req_i   (apb_req),
    .apb_rsp_i   (apb_rsp),
    .test_name_i (test_name),
    .errors_o    (errors),
    .checks_o    (checks)
  );

  // ##########################################################################
  // APB transfers, entered just after a rising edge.
  // ##########################################################################
  task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= 1'b1;
    apb_req.paddr   <= addr;
    apb_req.pwdata  <= data;
    @(posedge clk);
    apb_req.penable <= 1'b1;
    @(posedge clk);
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
  endtask

  task automatic apb_read(input logic [11:0] addr, output logic [31:0] data);
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= 1'b0;
    apb_req.paddr   <= addr;
    @(posedge clk);
    apb_req.penable <= 1'b1;
    @(negedge clk);
    data = apb_rsp.prdata;
    @(posedge clk);
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
  endtask

  task automatic run_op(input logic [8*16-1:0] name, input logic [15:0] a,
                        input logic [15:0] b, input logic op);
    logic [31:0] rd;
    int          polls;
    test_name = name;
    apb_write(REG_OPA, {16'd0, a});
    apb_write(REG_OPB, {16'd0, b});
    apb_write(REG_CTRL, {31'd0, op});
    polls = 1;
    apb_read(REG_STATUS, rd);
    while (!rd[0] && polls < 8) begin
      polls++;
      apb_read(REG_STATUS, rd);
    end
    if (!rd[0]) begin
      poll_errors++;
      $display("%0s: STATUS never showed done after %0d polls", name, polls);
    end
    apb_read(REG_RESULT, rd);
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles >= LIMIT) begin
      $display("timeout: run did not end within %0d cycles", LIMIT);
      $display("Checks failed");
      $finish;
    end
  end

  initial begin
    logic [31:0] rd;
    logic [15:0] ra;
    logic [15:0] rb;
    int unsigned seed;
    seed        = 32'hef771251;
    void'($urandom(seed));
    apb_req     = '0;
    test_name   = "reset";
    poll_errors = 0;
    cycles      = 0;
    while (reset) begin
      @(posedge clk);
    end

    // register behavior.
    apb_read(REG_STATUS, rd);
    test_name = "bad_offset";
    apb_write(12'h014, 32'h1);
    apb_read(12'h014, rd);
    test_name = "read_only_write";
    apb_write(REG_RESULT, 32'hFFFF);
    apb_write(REG_STATUS, 32'h1);
    run_op("ctrl_readback", 16'h4000, 16'h3C00, 1'b1);
    apb_read(REG_CTRL, rd);
    apb_read(REG_OPA, rd);

    run_op("norm_add", 16'h3C00, 16'h4000, 1'b0);
    run_op("norm_sub", 16'h4000, 16'h3C00, 1'b1);
    run_op("cancel_add", 16'h3C00, 16'hBC00, 1'b0);
    run_op("cancel_sub", 16'h4500, 16'h4500, 1'b1);
    run_op("unequal_exp", 16'h5640, 16'hC200, 1'b0);
    run_op("equal_exp", 16'h3555, 16'h3555, 1'b0);
    run_op("opposite_sign", 16'hC900, 16'h4100, 1'b0);

    run_op("sub_tiny", 16'h0001, 16'h0001, 1'b0);
    run_op("sub_carry", 16'h03FF, 16'h0001, 1'b0);
    run_op("sub_half", 16'h0200, 16'h0200, 1'b0);
    run_op("sub_result", 16'h0400, 16'h0001, 1'b1);
    run_op("sub_mixed", 16'h8123, 16'h0456, 1'b0);

    run_op("tie_low", 16'h3C00, 16'h1000, 1'b0);  // exactly half an ulp.
    run_op("above_tie", 16'h3C00, 16'h1001, 1'b0);
    run_op("sticky_far", 16'h3C00, 16'h0001, 1'b0);
    run_op("tie_even_down", 16'h6800, 16'h3C00, 1'b0);
    run_op("tie_even_up", 16'h6801, 16'h3C00, 1'b0);
    run_op("overflow_pos", 16'h7BFF, 16'h7BFF, 1'b0);
    run_op("overflow_neg", 16'hFBFF, 16'hFBFF, 1'b0);
    run_op("overflow_ulp", 16'h7BFF, 16'h5000, 1'b0);
    run_op("overflow_tie", 16'h7BFF, 16'h4C00, 1'b0);

    run_op("qnan_in", 16'h7E00, 16'h3C00, 1'b0);
    run_op("snan_in", 16'h3C00, 16'h7C01, 1'b0);
    run_op("inf_sub_inf", 16'h7C00, 16'h7C00, 1'b1);
    run_op("inf_add_ninf", 16'h7C00, 16'hFC00, 1'b0);
    run_op("inf_finite", 16'h7C00, 16'h4000, 1'b0);
    run_op("finite_sub_inf", 16'hC000, 16'h7C00, 1'b1);
    run_op("neg_zeros", 16'h8000, 16'h8000, 1'b0);
    run_op("nzero_sub_zero", 16'h8000, 16'h0000, 1'b1);
    run_op("zero_add_nzero", 16'h0000, 16'h8000, 1'b0);

    for (int n = 0; n < N_RANDOM; n++) begin
      ra = 16'($urandom());
      rb = 16'($urandom());
      run_op("random", ra, rb, 1'($urandom()));
    end

    @(posedge clk);
    $display("closing: %0d checks, %0d compare errors, %0d poll errors",
             checks, errors, poll_errors);
    if (errors == 0 && poll_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb/fp16_add_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module fp16_add_checker (
  input  logic               clk_i,
  input  logic               reset_i,
  input  apb_pkg::apb_req_t  apb_req_i,
  input  apb_pkg::apb_rsp_t  apb_rsp_i,
  input  logic [8*16-1:0]    test_name_i,
  output int                 errors_o,
  output int                 checks_o
);
  import apb_pkg::*;

  logic [15:0] opa;
  logic [15:0] opb;
  logic        op;
  logic        launched;
  int          since;       // negedges since the last CTRL write.
  logic [15:0] exp_result;
  logic [11:0] addr;
  logic        mapped;
  logic        read_only;
  logic [31:0] exp_data;

  // value in units of 2**-24, the smallest subnormal.
  function automatic longint scaled(input logic [15:0] x);
    longint m;
    int     e;
    e = x[14:10];
    m = (e == 0) ? longint'(x[9:0]) : longint'({1'b1, x[9:0]});
    if (e > 1) begin
      m = m << (e - 1);
    end
    return x[15] ? -m : m;
  endfunction

  // ##########################################################################
  // exact sum, then round to nearest even.
  // ##########################################################################
  function automatic logic [15:0] fp16_add_ref(input logic [15:0] a, input logic [15:0] b,
                                               input logic sub);
    logic [15:0]     bb;
    longint          s;
    longint unsigned mag;
    longint unsigned kept;
    longint unsigned rem;
    longint unsigned half;
    int              p;
    int              sh;
    int              e;
    logic            sgn;
    bb = b ^ {sub, 15'h0};
    if ((a[14:10] == 5'h1F && a[9:0] != 0) || (bb[14:10] == 5'h1F && bb[9:0] != 0)) begin
      return 16'h7E00;
    end
    if (a[14:0] == 15'h7C00 && bb[14:0] == 15'h7C00 && a[15] != bb[15]) begin
      return 16'h7E00;  // inf minus inf.
    end
    if (a[14:0] == 15'h7C00) begin
      return a;
    end
    if (bb[14:0] == 15'h7C00) begin
      return bb;
    end
    s = scaled(a) + scaled(bb);
    if (s == 0) begin
      return (a[14:0] == 0 && bb[14:0] == 0 && a[15] && bb[15]) ? 16'h8000 : 16'h0000;
    end
    sgn = (s < 0);
    mag = sgn ? -s : s;
    p = 0;
    for (int i = 0; i < 48; i++) begin
      if (mag[i]) begin
        p = i;
      end
    end
    if (p < 10) begin
      return {sgn, 5'd0, mag[9:0]};  // subnormal, exact.
    end
    sh   = p - 10;
    e    = p - 9;
    kept = mag >> sh;
    rem  = mag & ((64'd1 << sh) - 64'd1);
    half = (sh > 0) ? (64'd1 << (sh - 1)) : 64'd0;
    if (sh > 0 && (rem > half || (rem == half && kept[0]))) begin
      kept = kept + 1;
    end
    if (kept == 2048) begin
      kept = kept >> 1;
      e    = e + 1;
    end
    if (e >= 31) begin
      return {sgn, 5'h1F, 10'h0};
    end
    return {sgn, e[4:0], kept[9:0]};
  endfunction

  task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks_o++;
    if (exp !== act) begin
      errors_o++;
      $display("error %0s %0s: expected %h, actual %h", test_name_i, what, exp, act);
    end
  endtask

  initial begin
    errors_o = 0;
    checks_o = 0;
  end

  // ##########################################################################
  // every ACCESS cycle is checked mid cycle, where the bus is stable.
  // ##########################################################################
  always @(negedge clk_i) begin
    if (reset_i) begin
      opa        = '0;
      opb        = '0;
      op         = 1'b0;
      launched   = 1'b0;
      since      = 0;
      exp_result = '0;
    end else begin
      if (since < 1000) begin
        since++;
      end
      if (apb_req_i.psel && apb_req_i.penable) begin
        addr      = apb_req_i.paddr;
        read_only = (addr == REG_RESULT) || (addr == REG_STATUS);
        mapped    = read_only || addr == REG_OPA || addr == REG_OPB || addr == REG_CTRL;
        compare("pready", 32'd1, {31'd0, apb_rsp_i.pready});
        compare("pslverr", {31'd0, !mapped || (apb_req_i.pwrite && read_only)},
                {31'd0, apb_rsp_i.pslverr});
        if (apb_req_i.pwrite) begin
          if (addr == REG_OPA) begin
            opa = apb_req_i.pwdata[15:0];
          end else if (addr == REG_OPB) begin
            opb = apb_req_i.pwdata[15:0];
          end else if (addr == REG_CTRL) begin
            op         = apb_req_i.pwdata[0];
            launched   = 1'b1;
            since      = 0;
            exp_result = fp16_add_ref(opa, opb, op);
          end
        end else begin
          case (addr)
            REG_OPA:    exp_data = {16'd0, opa};
            REG_OPB:    exp_data = {16'd0, opb};
            REG_CTRL:   exp_data = {31'd0, op};
            REG_RESULT: exp_data = {16'd0, exp_result};
            REG_STATUS: exp_data = {31'd0, launched && since >= 4};  // done 3 edges on.
            default:    exp_data = 32'd0;
          endcase
          compare("prdata", exp_data, apb_rsp_i.prdata);
        end
      end
    end
  end

endmodule

`default_nettype wire

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;  // 10 ns period.
  end

  // held high over the first two rising edges.
  initial begin
    reset_o = 1'b1;
    repeat (2) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

`default_nettype wire

/* logic/fp16_add_apb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fp16_add_apb_top #(
  parameter int ADDR_WIDTH = 12
) (
  input  logic               clk_i,
  input  logic               reset_i,
  input  apb_pkg::apb_req_t  apb_req_i,
  output apb_pkg::apb_rsp_t  apb_rsp_o
);
  import fp16_pkg::*;

  logic   launch;
  fp16_t  opa;
  fp16_t  opb;
  fp_op_e op;
  logic   stage_valid;
  align_t stage;
  logic   result_valid;
  fp16_t  result;

  fp16_apb_regs #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_fp16_apb_regs (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .apb_req_i      (apb_req_i),
    .apb_rsp_o      (apb_rsp_o),
    .launch_o       (launch),
    .opa_o          (opa),
    .opb_o          (opb),
    .op_o           (op),
    .result_valid_i (result_valid),
    .result_i       (result)
  );

  // two registered stages, result two cycles after launch.
  fp16_align u_fp16_align (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .launch_i      (launch),
    .opa_i         (opa),
    .opb_i         (opb),
    .op_i          (op),
    .stage_valid_o (stage_valid),
    .stage_o       (stage)
  );

  fp16_normalize u_fp16_normalize (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .stage_valid_i  (stage_valid),
    .stage_i        (stage),
    .result_valid_o (result_valid),
    .result_o       (result)
  );

endmodule

`default_nettype wire

/* logic/fp16_apb_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module fp16_apb_regs #(
  parameter int ADDR_WIDTH = 12
) (
  input  logic               clk_i,
  input  logic               reset_i,
  input  apb_pkg::apb_req_t  apb_req_i,
  output apb_pkg::apb_rsp_t  apb_rsp_o,
  output logic               launch_o,
  output fp16_pkg::fp16_t    opa_o,
  output fp16_pkg::fp16_t    opb_o,
  output fp16_pkg::fp_op_e   op_o,
  input  logic               result_valid_i,
  input  fp16_pkg::fp16_t    result_i
);
  import apb_pkg::*;
  import fp16_pkg::*;

  logic [APB_ADDR_MAX-1:0] addr;
  logic                    access;
  logic                    mapped;
  logic                    read_only;
  logic                    wr_en;
  fp16_t                   result_q;
  logic                    done_q;

  assign addr      = APB_ADDR_MAX'(apb_req_i.paddr[ADDR_WIDTH-1:0]);
  assign access    = apb_req_i.psel & apb_req_i.penable;
  assign mapped    = addr inside {REG_OPA, REG_OPB, REG_CTRL, REG_RESULT, REG_STATUS};
  assign read_only = (addr == REG_RESULT) | (addr == REG_STATUS);
  assign wr_en     = access & apb_req_i.pwrite & mapped & ~read_only;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      opa_o    <= '0;
      opb_o    <= '0;
      op_o     <= FP_ADD;
      launch_o <= 1'b0;
      result_q <= '0;
      done_q   <= 1'b0;
    end else begin
      launch_o <= wr_en & (addr == REG_CTRL);  // one cycle after the write.
      if (wr_en & (addr == REG_OPA)) begin
        opa_o <= fp16_t'(apb_req_i.pwdata[15:0]);
      end
      if (wr_en & (addr == REG_OPB)) begin
        opb_o <= fp16_t'(apb_req_i.pwdata[15:0]);
      end
      if (wr_en & (addr == REG_CTRL)) begin
        op_o <= fp_op_e'(apb_req_i.pwdata[0]);
      end
      if (result_valid_i) begin
        result_q <= result_i;
      end
      if (launch_o) begin
        done_q <= 1'b0;
      end else if (result_valid_i) begin
        done_q <= 1'b1;
      end
    end
  end

  // ##########################################################################
  // read data and response.
  // ##########################################################################
  always_comb begin
    apb_rsp_o         = '0;
    apb_rsp_o.pready  = 1'b1;                  // no wait states.
    apb_rsp_o.pslverr = access & (~mapped | (apb_req_i.pwrite & read_only));
    if (access & ~apb_req_i.pwrite) begin
      case (addr)
        REG_OPA:    apb_rsp_o.prdata = {{(APB_DATA_W-16){1'b0}}, opa_o};
        REG_OPB:    apb_rsp_o.prdata = {{(APB_DATA_W-16){1'b0}}, opb_o};
        REG_CTRL:   apb_rsp_o.prdata = {{(APB_DATA_W-1){1'b0}}, op_o};
        REG_RESULT: apb_rsp_o.prdata = {{(APB_DATA_W-16){1'b0}}, result_q};
        REG_STATUS: apb_rsp_o.prdata = {{(APB_DATA_W-1){1'b0}}, done_q};
        default:    apb_rsp_o.prdata = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/fp16_normalize.sv */
`timescale 1ns/1ps
`default_nettype none

module fp16_normalize (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              stage_valid_i,
  input  fp16_pkg::align_t  stage_i,
  output logic              result_valid_o,
  output fp16_pkg::fp16_t   result_o
);
  import fp16_pkg::*;

  localparam int RND_W = EXP_BITS + 1 + MAN_BITS;

  logic [LZC_BITS-1:0]  lz;
  logic                 empty;
  logic [EXP_BITS:0]    lz_ext;
  logic [EXP_BITS:0]    shamt;
  logic [SUM_BITS-1:0]  norm;
  logic [EXP_BITS:0]    exp_pre;
  logic                 guard;
  logic                 rnd;
  logic                 stk;
  logic                 round_up;
  logic [RND_W-1:0]     rounded;
  fp16_t                result_d;

  lzc #(
    .WIDTH     (SUM_BITS),
    .CNT_WIDTH (LZC_BITS)
  ) u_lzc (
    .in_i    (stage_i.sum),
    .cnt_o   (lz),
    .empty_o (empty)
  );

  // ##########################################################################
  // normalize, stopping at exponent 1 for subnormal results.
  // ##########################################################################
  assign lz_ext = (EXP_BITS + 1)'(lz);
  assign shamt  = (lz_ext > stage_i.exponent) ? stage_i.exponent : lz_ext;
  assign norm   = stage_i.sum << shamt;

  // hidden bit lands on the msb, or stays 0 for a subnormal.
  assign exp_pre = norm[SUM_BITS-1] ?
                   stage_i.exponent + (EXP_BITS + 1)'(1) - shamt : '0;

  // ##########################################################################
  // round to nearest even.
  // ##########################################################################
  assign guard    = norm[GRD_BITS];
  assign rnd      = norm[GRD_BITS-1];
  assign stk      = (|norm[GRD_BITS-2:0]) | stage_i.sticky;
  assign round_up = guard & (rnd | stk | norm[GRD_BITS+1]);

  // a mantissa carry walks into the exponent by itself.
  assign rounded = {exp_pre, norm[SUM_BITS-2 -: MAN_BITS]} + RND_W'(round_up);

  always_comb begin
    result_d.sign     = stage_i.sign;
    result_d.exponent = rounded[MAN_BITS +: EXP_BITS];
    result_d.mantissa = rounded[MAN_BITS-1:0];
    if (stage_i.special) begin
      result_d = stage_i.special_res;
    end else if (empty) begin
      result_d.exponent = '0;
      result_d.mantissa = '0;
    end else if (rounded[RND_W-1 -: EXP_BITS+1] >= (EXP_BITS + 1)'(EXP_INF)) begin
      result_d.exponent = '1;                       // overflow to infinity.
      result_d.mantissa = '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      result_valid_o <= 1'b0;
    end else begin
      result_valid_o <= stage_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (stage_valid_i) begin
      result_o <= result_d;
    end
  end

endmodule

`default_nettype wire

/* logic/fp16_align.sv */
`timescale 1ns/1ps
`default_nettype none

module fp16_align (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              launch_i,
  input  fp16_pkg::fp16_t   opa_i,
  input  fp16_pkg::fp16_t   opb_i,
  input  fp16_pkg::fp_op_e  op_i,
  output logic              stage_valid_o,
  output fp16_pkg::align_t  stage_o
);
  import fp16_pkg::*;

  localparam int SHIFT_W = PREC_BITS + GRD_BITS;

  fp16_t                b_eff;
  logic                 den_a;
  logic                 den_b;
  logic                 zero_a;
  logic                 zero_b;
  logic                 inf_a;
  logic                 inf_b;
  logic                 nan_a;
  logic                 nan_b;
  logic [EXP_BITS-1:0]  exp_a;
  logic [EXP_BITS-1:0]  exp_b;
  logic [PREC_BITS-1:0] man_a;
  logic [PREC_BITS-1:0] man_b;
  logic                 a_big;
  logic                 same_mag;
  logic                 eff_sub;
  logic                 sign_l;
  logic [EXP_BITS-1:0]  exp_l;
  logic [EXP_BITS-1:0]  exp_s;
  logic [PREC_BITS-1:0] man_l;
  logic [PREC_BITS-1:0] man_s;
  logic [EXP_BITS-1:0]  diff;
  logic [SHIFT_W-1:0]   small_full;
  logic [SHIFT_W-1:0]   small_sh;
  logic [SHIFT_W-1:0]   lost_mask;
  logic                 sticky;
  logic [SUM_BITS:0]    big_w;
  logic [SUM_BITS:0]    small_w;
  logic [SUM_BITS:0]    sum_w;
  align_t               stage_d;

  // ##########################################################################
  // unpack and classify.
  // ##########################################################################
  always_comb begin
    b_eff      = opb_i;
    b_eff.sign = opb_i.sign ^ (op_i == FP_SUB);  // subtract flips b.
  end

  assign den_a  = opa_i.exponent == '0;
  assign den_b  = b_eff.exponent == '0;
  assign zero_a = den_a & (opa_i.mantissa == '0);
  assign zero_b = den_b & (b_eff.mantissa == '0);
  assign inf_a  = (opa_i.exponent == EXP_BITS'(EXP_INF)) & (opa_i.mantissa == '0);
  assign inf_b  = (b_eff.exponent == EXP_BITS'(EXP_INF)) & (b_eff.mantissa == '0);
  assign nan_a  = (opa_i.exponent == EXP_BITS'(EXP_INF)) & (opa_i.mantissa != '0);
  assign nan_b  = (b_eff.exponent == EXP_BITS'(EXP_INF)) & (b_eff.mantissa != '0);

  // subnormals sit at exponent 1 with a hidden zero.
  assign exp_a = den_a ? EXP_BITS'(1) : opa_i.exponent;
  assign exp_b = den_b ? EXP_BITS'(1) : b_eff.exponent;
  assign man_a = {~den_a, opa_i.mantissa};
  assign man_b = {~den_b, b_eff.mantissa};

  assign a_big    = {opa_i.exponent, opa_i.mantissa} >= {b_eff.exponent, b_eff.mantissa};
  assign same_mag = {opa_i.exponent, opa_i.mantissa} == {b_eff.exponent, b_eff.mantissa};
  assign eff_sub  = opa_i.sign ^ b_eff.sign;

  // ##########################################################################
  // swap, align and add.
  // ##########################################################################
  assign sign_l = a_big ? opa_i.sign : b_eff.sign;
  assign exp_l  = a_big ? exp_a : exp_b;
  assign exp_s  = a_big ? exp_b : exp_a;
  assign man_l  = a_big ? man_a : man_b;
  assign man_s  = a_big ? man_b : man_a;
  assign diff   = exp_l - exp_s;

  assign small_full = {man_s, {GRD_BITS{1'b0}}};
  assign small_sh   = small_full >> diff;
  assign lost_mask  = (SHIFT_W'(1) << diff) - SHIFT_W'(1);  // all ones past the width.
  assign sticky     = |(small_full & lost_mask);

  // sticky rides one place below the sum, so a borrow still marks it.
  assign big_w   = {1'b0, man_l, {GRD_BITS{1'b0}}, 1'b0};
  assign small_w = {1'b0, small_sh, sticky};
  assign sum_w   = eff_sub ? big_w - small_w : big_w + small_w;

  always_comb begin
    stage_d.exponent    = {1'b0, exp_l};
    stage_d.sum         = sum_w[SUM_BITS:1];
    stage_d.sticky      = sum_w[0];
    stage_d.special     = 1'b1;
    stage_d.special_res = fp16_t'(FP16_QNAN);
    if (zero_a & zero_b) begin
      stage_d.sign = opa_i.sign & b_eff.sign;      // -0 only from two -0.
    end else if (eff_sub & same_mag) begin
      stage_d.sign = 1'b0;                         // exact cancellation.
    end else begin
      stage_d.sign = sign_l;
    end
    if (nan_a | nan_b | (inf_a & inf_b & eff_sub)) begin
      stage_d.special_res = fp16_t'(FP16_QNAN);
    end else if (inf_a) begin
      stage_d.special_res = '{sign: opa_i.sign, exponent: '1, mantissa: '0};
    end else if (inf_b) begin
      stage_d.special_res = '{sign: b_eff.sign, exponent: '1, mantissa: '0};
    end else begin
      stage_d.special = 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      stage_valid_o <= 1'b0;
    end else begin
      stage_valid_o <= launch_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (launch_i) begin
      stage_o <= stage_d;
    end
  end

endmodule

`default_nettype wire

/* logic/lzc.sv */
`timescale 1ns/1ps
`default_nettype none

module lzc #(
  parameter int WIDTH     = 25,
  parameter int CNT_WIDTH = 5
) (
  input  logic [WIDTH-1:0]     in_i,
  output logic [CNT_WIDTH-1:0] cnt_o,
  output logic                 empty_o
);

  // the highest set bit is found last and wins.
  always_comb begin
    cnt_o = CNT_WIDTH'(WIDTH);
    for (int i = 0; i < WIDTH; i++) begin
      if (in_i[i]) begin
        cnt_o = CNT_WIDTH'(WIDTH - 1 - i);
      end
    end
  end

  assign empty_o = ~|in_i;

endmodule

`default_nettype wire

/* logic/apb_pkg.sv */
`default_nettype none

package apb_pkg;

  localparam int APB_ADDR_MAX = 12;
  localparam int APB_DATA_W   = 32;

  typedef struct packed {
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [APB_ADDR_MAX-1:0] paddr;
    logic [APB_DATA_W-1:0]   pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [APB_DATA_W-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
  } apb_rsp_t;

  // ##########################################################################
  // register map.
  // ##########################################################################
  localparam logic [APB_ADDR_MAX-1:0] REG_OPA    = 12'h000;
  localparam logic [APB_ADDR_MAX-1:0] REG_OPB    = 12'h004;
  localparam logic [APB_ADDR_MAX-1:0] REG_CTRL   = 12'h008;  // bit 0 opcode.
  localparam logic [APB_ADDR_MAX-1:0] REG_RESULT = 12'h00C;
  localparam logic [APB_ADDR_MAX-1:0] REG_STATUS = 12'h010;  // bit 0 done.

endpackage

`default_nettype wire

/* logic/fp16_pkg.sv */
`default_nettype none

package fp16_pkg;

  // ##########################################################################
  // half precision format, 1-5-10.
  // ##########################################################################
  localparam int EXP_BITS  = 5;
  localparam int MAN_BITS  = 10;
  localparam int BIAS      = 15;
  localparam int EXP_INF   = 2 * BIAS + 1;     // all-ones exponent field.
  localparam int PREC_BITS = MAN_BITS + 1;     // hidden bit included.
  localparam int GRD_BITS  = 13;
  localparam int SUM_BITS  = 1 + PREC_BITS + GRD_BITS;
  localparam int LZC_BITS  = $clog2(SUM_BITS + 1);

  localparam logic [15:0] FP16_QNAN = 16'h7E00;

  typedef struct packed {
    logic                sign;
    logic [EXP_BITS-1:0] exponent;
    logic [MAN_BITS-1:0] mantissa;
  } fp16_t;

  typedef enum logic {
    FP_ADD = 1'b0,
    FP_SUB = 1'b1
  } fp_op_e;

  // carried from the align stage into the normalize stage.
  typedef struct packed {
    logic                sign;
    logic [EXP_BITS:0]   exponent;     // exponent of the larger operand.
    logic [SUM_BITS-1:0] sum;          // carry, precision and guard bits.
    logic                sticky;
    logic                special;
    fp16_t               special_res;
  } align_t;

endpackage

`default_nettype wire
